// ==== logic/la_defines.svh ====
`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

// Probe channels per sample
`define LA_NUM_PROBES 9

// Capture depth, sample counter and downsample ratio width
`define LA_DEPTH_BITS 16

// Trigger source select code width
`define LA_TRIG_SRC_BITS 6

// Probe group select code width
`define LA_GROUP_BITS 3

// Seen on unused group codes, channel 0 high
`define LA_IDLE_PATTERN 9'h155

`endif

// ==== logic/la_pkg.sv ====
`include "la_defines.svh"

package la_pkg;

   // One sample across all probe channels
   typedef logic [`LA_NUM_PROBES-1:0] probe_vec_t;

   // Two samples per channel, older one in the upper bit
   typedef logic [2*`LA_NUM_PROBES-1:0] fifo_word_t;

   // Depth, sample count and downsample ratio
   typedef logic [`LA_DEPTH_BITS-1:0] depth_t;

   typedef logic [`LA_TRIG_SRC_BITS-1:0] trig_src_t;   // Trigger source code

   typedef logic [`LA_GROUP_BITS-1:0] group_t;   // Probe group code

   // Capture controller states
   typedef enum logic [1:0] {
      CAP_IDLE  = 2'd0,   // Waiting for arm
      CAP_ARMED = 2'd1,   // Waiting for trigger
      CAP_RUN   = 2'd2    // Taking samples
   } cap_state_t;

endpackage

// ==== logic/la_trigger.sv ====
`timescale 1ns/100ps
`include "la_defines.svh"

module la_trigger import la_pkg::*; (
   input  logic       observer_clk,
   input  logic       reset,
   input  trig_src_t  trigger_source,
   input  logic       manual_capture,
   input  logic       hs1,
   input  probe_vec_t tu_la_debug,
   input  logic [3:0] io,
   input  logic [7:0] userio,
   output logic       trigger_edge
);

   logic selected;     // Chosen line after polarity
   logic go_async;
   logic go_meta;
   logic go_sync;
   logic go_sync_d;

   // Source decode
   always_comb begin
      if (trigger_source[5]) begin
         selected = io[trigger_source[1:0]] ^ trigger_source[3];   // io 1 to 4
      end else if (trigger_source[3]) begin
         selected = userio[trigger_source[2:0]] ^ trigger_source[4];   // userio 0 to 7
      end else begin
         case (trigger_source)
            6'd0:    selected = hs1;
            6'd1:    selected = tu_la_debug[0];
            6'd2:    selected = tu_la_debug[1];
            default: selected = 1'b0;
         endcase
      end
   end

   // Manual capture joins before the synchroniser so it gets the same latency
   assign go_async = selected | manual_capture;

   // Two flop synchroniser, then a delayed copy for edge detection
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         go_meta   <= 1'b0;
         go_sync   <= 1'b0;
         go_sync_d <= 1'b0;
      end else begin
         go_meta   <= go_async;
         go_sync   <= go_meta;
         go_sync_d <= go_sync;
      end
   end

   // Registered rising edge pulse
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trigger_edge <= 1'b0;
      end else begin
         trigger_edge <= go_sync & ~go_sync_d;
      end
   end

endmodule

// ==== logic/la_probe_select.sv ====
`timescale 1ns/100ps
`include "la_defines.svh"

module la_probe_select import la_pkg::*; (
   input  logic       observer_clk,
   input  logic [3:0] io,
   input  logic       hs1,
   input  logic       hs2,
   input  logic       aux_mcx,
   input  logic       trig_mcx,
   input  logic       adc_sample_clk,
   input  logic [7:0] userio,
   input  logic       userio_clk,
   input  probe_vec_t tu_la_debug,
   input  logic [7:0] trace_data,
   input  logic       trace_fe_clk,
   input  probe_vec_t trace_debug,
   input  group_t     capture_group,
   output probe_vec_t probes
);

   probe_vec_t group_mux;

   // Channel 0 is the rightmost signal of each concatenation
   always_comb begin
      case (capture_group)
         3'd0: begin
            group_mux = {adc_sample_clk, trig_mcx, aux_mcx, hs2, hs1, io};
         end
         3'd1: begin
            group_mux = {userio_clk, userio};
         end
         3'd2: begin
            group_mux = tu_la_debug;
         end
         3'd3: begin
            group_mux = {trace_fe_clk, trace_data};
         end
         3'd4: begin
            group_mux = trace_debug;
         end
         default: begin
            group_mux = `LA_IDLE_PATTERN;   // Recognisable filler
         end
      endcase
   end

   // One sampling point for all nine channels
   always_ff @(posedge observer_clk) begin
      probes <= group_mux;
   end

endmodule

// ==== logic/la_capture_ctrl.sv ====
`timescale 1ns/100ps
`include "la_defines.svh"

module la_capture_ctrl import la_pkg::*; (
   input  logic       observer_clk,
   input  logic       reset,
   input  logic       arm,
   input  logic       trigger_edge,
   input  probe_vec_t probes,
   input  depth_t     capture_depth,
   input  depth_t     downsample,
   output logic       fifo_wr,
   output fifo_word_t fifo_wr_data,
   output logic       fifo_clear,
   output logic       capture_start,
   output logic       capture_done,
   output logic       capturing
);

   cap_state_t state;

   logic       arm_meta;
   logic       arm_sync;
   logic       arm_sync_d;
   logic       arm_rise;

   depth_t     ds_cnt;        // Cycles since last strobe
   depth_t     sample_cnt;    // Strobes so far in this capture
   logic       strobe;
   logic       last_sample;
   logic       pair_second;   // Next strobe completes a word

   probe_vec_t sample_old;
   probe_vec_t sample_new;

   // Host arm level is asynchronous
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         arm_meta   <= 1'b0;
         arm_sync   <= 1'b0;
         arm_sync_d <= 1'b0;
      end else begin
         arm_meta   <= arm;
         arm_sync   <= arm_meta;
         arm_sync_d <= arm_sync;
      end
   end

   assign arm_rise   = arm_sync & ~arm_sync_d;
   assign fifo_clear = arm_sync;

   assign capturing   = (state == CAP_RUN);
   assign strobe      = capturing && (ds_cnt == downsample);
   assign last_sample = (sample_cnt == capture_depth - depth_t'(1));

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         state         <= CAP_IDLE;
         capture_start <= 1'b0;
         capture_done  <= 1'b0;
         fifo_wr       <= 1'b0;
         ds_cnt        <= '0;
         sample_cnt    <= '0;
         pair_second   <= 1'b0;
      end else begin
         capture_start <= 1'b0;   // Pulses by default
         capture_done  <= 1'b0;
         fifo_wr       <= 1'b0;
         case (state)
            CAP_IDLE: begin
               if (arm_rise) begin
                  state <= CAP_ARMED;
               end
            end
            CAP_ARMED: begin
               if (trigger_edge) begin
                  state         <= CAP_RUN;
                  capture_start <= 1'b1;
                  ds_cnt        <= '0;
                  sample_cnt    <= '0;
                  pair_second   <= 1'b0;
               end
            end
            CAP_RUN: begin
               if (strobe) begin
                  ds_cnt      <= '0;
                  sample_cnt  <= sample_cnt + depth_t'(1);
                  pair_second <= ~pair_second;
                  fifo_wr     <= pair_second;   // Every second sample
                  if (last_sample) begin
                     state        <= CAP_IDLE;   // Needs a fresh arm edge
                     capture_done <= 1'b1;
                  end
               end else begin
                  ds_cnt <= ds_cnt + depth_t'(1);
               end
            end
            default: begin
               state <= CAP_IDLE;
            end
         endcase
      end
   end

   // Per channel two bit shift on each strobe
   always_ff @(posedge observer_clk) begin
      if (strobe) begin
         sample_old <= sample_new;
         sample_new <= probes;
      end
   end

   // Channel c in bits 2c+1:2c, older sample on top
   always_comb begin
      for (int c = 0; c < `LA_NUM_PROBES; c++) begin
         fifo_wr_data[2*c+1] = sample_old[c];
         fifo_wr_data[2*c]   = sample_new[c];
      end
   end

endmodule

// ==== logic/la_top.sv ====
`timescale 1ns/100ps
`include "la_defines.svh"

module la_top import la_pkg::*; (
   input  logic       observer_clk,
   input  logic       reset,

   // Host configuration levels
   input  trig_src_t  trigger_source,
   input  group_t     capture_group,
   input  depth_t     capture_depth,
   input  depth_t     downsample,
   input  logic       arm,
   input  logic       manual_capture,

   // Observed signals
   input  logic [3:0] io,
   input  logic       hs1,
   input  logic       hs2,
   input  logic       aux_mcx,
   input  logic       trig_mcx,
   input  logic       adc_sample_clk,
   input  logic [7:0] userio,
   input  logic       userio_clk,
   input  probe_vec_t tu_la_debug,
   input  logic [7:0] trace_data,
   input  logic       trace_fe_clk,
   input  probe_vec_t trace_debug,

   // FIFO side and status
   output logic       fifo_wr,
   output fifo_word_t fifo_wr_data,
   output logic       fifo_clear,
   output logic       capture_start,
   output logic       capture_done,
   output logic       capturing
);

   logic       trigger_edge;
   probe_vec_t probes;

   la_trigger i_trigger (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .trigger_source (trigger_source),
      .manual_capture (manual_capture),
      .hs1            (hs1),
      .tu_la_debug    (tu_la_debug),
      .io             (io),
      .userio         (userio),
      .trigger_edge   (trigger_edge)
   );

   la_probe_select i_probe_select (
      .observer_clk   (observer_clk),
      .io             (io),
      .hs1            (hs1),
      .hs2            (hs2),
      .aux_mcx        (aux_mcx),
      .trig_mcx       (trig_mcx),
      .adc_sample_clk (adc_sample_clk),
      .userio         (userio),
      .userio_clk     (userio_clk),
      .tu_la_debug    (tu_la_debug),
      .trace_data     (trace_data),
      .trace_fe_clk   (trace_fe_clk),
      .trace_debug    (trace_debug),
      .capture_group  (capture_group),
      .probes         (probes)
   );

   la_capture_ctrl i_capture_ctrl (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .arm            (arm),
      .trigger_edge   (trigger_edge),
      .probes         (probes),
      .capture_depth  (capture_depth),
      .downsample     (downsample),
      .fifo_wr        (fifo_wr),
      .fifo_wr_data   (fifo_wr_data),
      .fifo_clear     (fifo_clear),
      .capture_start  (capture_start),
      .capture_done   (capture_done),
      .capturing      (capturing)
   );

endmodule

// ==== test/la_tb.sv ====
`timescale 1ns/100ps
`include "la_defines.svh"

module la_tb import la_pkg::*; ();

   localparam trig_src_t TRIG_HS1     = 6'h00;
   localparam trig_src_t TRIG_IO2_INV = 6'h29;   // io 2, inverted
   localparam trig_src_t TRIG_USERIO5 = 6'h0d;   // userio 5, straight

   logic       observer_clk;
   logic       reset;
   trig_src_t  trigger_source;
   group_t     capture_group;
   depth_t     capture_depth;
   depth_t     downsample;
   logic       arm;
   logic       manual_capture;
   logic [3:0] io;
   logic       hs1;
   logic       hs2;
   logic       aux_mcx;
   logic       trig_mcx;
   logic       adc_sample_clk;
   logic [7:0] userio;
   logic       userio_clk;
   probe_vec_t tu_la_debug;
   logic [7:0] trace_data;
   logic       trace_fe_clk;
   probe_vec_t trace_debug;
   logic       fifo_wr;
   fifo_word_t fifo_wr_data;
   logic       fifo_clear;
   logic       capture_start;
   logic       capture_done;
   logic       capturing;

   integer     seed = 28731;
   int         error_count = 0;
   int         tests_passed = 0;
   int         tests_failed = 0;
   int         errors_at_start;
   string      test_name;
   int         cycle = 0;
   int         start_count = 0;
   int         wr_count = 0;
   int         done_count = 0;
   int         base_start;
   int         base_wr;
   int         base_done;
   int         last_wr_cycle = 0;
   bit         have_last_wr = 1'b0;
   int         last_gap = 0;
   bit         gap_ready = 1'b0;   // Holds for one cycle after a measured write
   bit         check_data = 1'b0;
   int         wr_gap = 2;
   fifo_word_t expected_word;

   la_top i_dut (.*);

   initial begin
      observer_clk = 1'b0;
      forever #10 observer_clk = ~observer_clk;
   end

   always @(posedge observer_clk) begin
      cycle <= cycle + 1;
   end

   // Pulse counts and write spacing, read on the falling edge
   always @(negedge observer_clk) begin
      gap_ready = 1'b0;
      if (!reset) begin
         if (capture_start) begin
            start_count++;
            have_last_wr = 1'b0;   // Spacing restarts with each capture
         end
         if (capture_done) begin
            done_count++;
         end
         if (fifo_wr) begin
            wr_count++;
            last_gap      = cycle - last_wr_cycle;
            gap_ready     = have_last_wr;
            last_wr_cycle = cycle;
            have_last_wr  = 1'b1;
         end
      end
   end

   a_start_once: assert property (@(posedge observer_clk) disable iff (reset)
      capture_start |-> capturing && !$past(capture_start))
      else note_failure("capture_start not a single pulse at the start of capturing");
   a_done_idle: assert property (@(posedge observer_clk) disable iff (reset)
      capture_done |-> !capturing)
      else note_failure("capture_done while capturing is still high");
   a_wr_in_run: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr |-> $past(capturing))
      else note_failure("fifo_wr outside a capture");
   a_wr_data: assert property (@(posedge observer_clk) disable iff (reset)
      (fifo_wr && check_data) |-> fifo_wr_data == expected_word)
      else note_failure($sformatf("FIFO word %h, expected %h", fifo_wr_data, expected_word));
   a_wr_spacing: assert property (@(posedge observer_clk) disable iff (reset)
      gap_ready |-> last_gap == wr_gap)
      else note_failure($sformatf("FIFO writes %0d cycles apart, expected %0d",
                                  last_gap, wr_gap));
   a_clear_sync: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_clear == $past(arm, 2))
      else note_failure("fifo_clear does not follow arm through two flops");

   // Group 1 puts userio 0 to 7 on channels 0 to 7 and userio_clk on channel 8
   function automatic probe_vec_t userio_group();
      probe_vec_t v;
      for (int c = 0; c < 8; c++) begin
         v[c] = userio[c];
      end
      v[8] = userio_clk;
      return v;
   endfunction

   // Word for a constant input, both bits of a channel equal
   function automatic fifo_word_t paired(input probe_vec_t v);
      fifo_word_t w;
      for (int c = 0; c < `LA_NUM_PROBES; c++) begin
         w[2*c+1] = v[c];
         w[2*c]   = v[c];
      end
      return w;
   endfunction

   function automatic int budget(input int depth, input int ds);
      return (depth + 4) * (ds + 1) + 100;
   endfunction

   task automatic note_failure(input string msg);
      error_count++;
      $display("FAIL %0t: %s", $time, msg);
   endtask

   task automatic tick(input int n);
      repeat (n) @(negedge observer_clk);
   endtask

   // Arm has to pass its synchroniser before a trigger counts
   task automatic rearm();
      arm = 1'b0;
      tick(4);
      arm = 1'b1;
      tick(6);
   endtask

   task automatic configure(input int depth, input int ds);
      capture_depth = depth_t'(depth);
      downsample    = depth_t'(ds);
      wr_gap        = 2 * (ds + 1);
   endtask

   task automatic wait_done(input int limit);
      int waited;
      waited = 0;
      while (!capture_done && waited < limit) begin
         tick(1);
         waited++;
      end
      if (!capture_done) begin
         error_count++;
         $display("%s: capture did not finish within %0d cycles", test_name, limit);
      end
   endtask

   // Counts since the start of the current test
   task automatic expect_counts(input int starts, input int writes);
      tick(2);
      assert (start_count - base_start == starts && done_count - base_done == starts)
         else note_failure($sformatf("%0d starts and %0d dones, expected %0d each",
                                     start_count - base_start, done_count - base_done, starts));
      assert (wr_count - base_wr == writes)
         else note_failure($sformatf("%0d FIFO writes, expected %0d",
                                     wr_count - base_wr, writes));
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      errors_at_start = error_count;
      base_start      = start_count;
      base_wr         = wr_count;
      base_done       = done_count;
   endtask

   task automatic end_test();
      if (error_count == errors_at_start) begin
         tests_passed++;
         $display("%s: passed", test_name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", test_name, error_count - errors_at_start);
      end
   endtask

   initial begin
      reset          = 1'b1;
      trigger_source = TRIG_HS1;
      capture_group  = 3'd1;
      arm            = 1'b0;
      manual_capture = 1'b0;
      io             = 4'hf;
      hs1            = 1'b0;
      hs2            = 1'b0;
      aux_mcx        = 1'b0;
      trig_mcx       = 1'b0;
      adc_sample_clk = 1'b0;
      userio         = 8'($random(seed));
      userio_clk     = 1'($random(seed));
      tu_la_debug    = '0;
      trace_data     = '0;
      trace_fe_clk   = 1'b0;
      trace_debug    = '0;
      expected_word  = '0;
      configure(10, 0);
      tick(16);
      reset = 1'b0;
      tick(1);

      begin_test("reset_and_unarmed_trigger");
      assert (!fifo_wr && !capture_start && !capture_done && !capturing && !fifo_clear)
         else note_failure("control outputs not low after reset");
      hs1 = 1'b1;
      tick(3);
      hs1 = 1'b0;
      tick(20);
      expect_counts(0, 0);
      end_test();

      begin_test("word_count_and_content");
      expected_word = paired(userio_group());
      check_data    = 1'b1;
      rearm();
      hs1 = 1'b1;
      wait_done(budget(10, 0));
      hs1 = 1'b0;
      expect_counts(1, 5);
      end_test();

      begin_test("downsample_spacing");
      configure(9, 3);   // Odd depth drops the last half pair
      rearm();
      hs1 = 1'b1;
      wait_done(budget(9, 3));
      hs1 = 1'b0;
      expect_counts(1, 4);
      end_test();

      begin_test("trigger_polarity");
      check_data = 1'b0;
      configure(4, 0);
      io[1]          = 1'b1;   // Reads low through the inversion
      trigger_source = TRIG_IO2_INV;
      rearm();
      io[1] = 1'b0;
      wait_done(budget(4, 0));
      expect_counts(1, 2);
      rearm();
      io[1] = 1'b1;
      tick(20);
      expect_counts(1, 2);
      userio[5]      = 1'b0;
      trigger_source = TRIG_USERIO5;   // Still armed here
      tick(6);
      userio[5] = 1'b1;
      wait_done(budget(4, 0));
      expect_counts(2, 4);
      rearm();
      userio[5] = 1'b0;
      tick(20);
      expect_counts(2, 4);
      end_test();

      begin_test("one_capture_per_arm");
      trigger_source = TRIG_HS1;
      rearm();
      manual_capture = 1'b1;
      wait_done(budget(4, 0));
      manual_capture = 1'b0;
      expect_counts(1, 2);
      hs1 = 1'b1;
      tick(3);
      hs1 = 1'b0;
      tick(20);
      expect_counts(1, 2);
      rearm();
      manual_capture = 1'b1;
      wait_done(budget(4, 0));
      manual_capture = 1'b0;
      expect_counts(2, 4);
      end_test();

      begin_test("idle_group_pattern");
      capture_group = 3'd7;
      expected_word = paired(`LA_IDLE_PATTERN);
      check_data    = 1'b1;
      configure(6, 1);
      rearm();
      manual_capture = 1'b1;
      wait_done(budget(6, 1));
      manual_capture = 1'b0;
      expect_counts(1, 3);
      end_test();

      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (error_count == 0 && tests_failed == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Sum of per capture budgets plus the reset time
   initial begin
      int limit;
      limit = 16 + budget(0, 0) + budget(10, 0) + budget(9, 3) + 4 * budget(4, 0)
              + 3 * budget(4, 0) + budget(6, 1);
      repeat (limit) @(posedge observer_clk);
      $display("Watchdog expired after %0d cycles, the tests did not finish", limit);
      $display("Test FAILED");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+logic
logic/la_pkg.sv
logic/la_trigger.sv
logic/la_probe_select.sv
logic/la_capture_ctrl.sv
logic/la_top.sv
test/la_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the logic analyzer capture core with Verilator and runs its testbench.
# A failure is reported through the exit status.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module la_tb -Mdir obj_dir -o la_sim -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/la_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
   echo "Simulation ended without a result line, see $LOG"
   exit 1
fi

exit 0
